// ==== src/udp_rx_defines.svh ====
// udp receiver constants
// board addresses, Ethernet/IPv4/UDP protocol codes and fixed header sizes
// shared by the sequencer and the header match

`ifndef UDP_RX_DEFINES_SVH
`define UDP_RX_DEFINES_SVH

`define UDP_BOARD_MAC       48'h00_11_22_33_44_55
`define UDP_BOARD_IP        32'hC0_A8_1F_17 // 192.168.31.23

`define ETH_PREAMBLE_BYTE   8'h55
`define ETH_SFD_BYTE        8'hD5
`define ETH_PREAMBLE_MIN    6               // preamble bytes before the delimiter
`define ETH_HDR_BYTES       14              // dest MAC, src MAC, ethertype

`define ETH_TYPE_IPV4       16'h0800
`define IP_VERSION_4        4'd4
`define IP_PROTO_UDP        8'd17

`define UDP_HDR_BYTES       8               // ports, length, checksum

`endif

// ==== src/udp_rx_pkg.sv ====
// udp receiver types
// field widths of the Ethernet, IPv4 and UDP headers and the frame section
// enum that the sequencer hands to the side blocks

package udp_rx_pkg;

	typedef logic [7:0]  byte_t;        // one gmii byte
	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [15:0] udp_port_t;
	typedef logic [15:0] len_t;         // length or byte index

	// position inside a section, wide enough for a 60 byte ip header
	typedef logic [5:0]  sect_cnt_t;

	typedef enum logic [2:0] {
		SECT_IDLE,                      // waiting for preamble
		SECT_SFD,                       // preamble seen, waiting for delimiter
		SECT_ETH,                       // ethernet header
		SECT_IP,                        // ip header including options
		SECT_UDP,                       // udp header
		SECT_PAYLOAD,
		SECT_DRAIN                      // padding and fcs
	} frame_sect_t;

endpackage

// ==== src/eth_rx_sequencer.sv ====
// Ethernet receive sequencer
// finds preamble and delimiter on the gmii stream, then tags every frame
// byte with its section and its position in that section. The section
// lengths come from the ip header length and the udp length fields.

`include "udp_rx_defines.svh"

module eth_rx_sequencer (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  logic                    gmii_rxdv,
	input  udp_rx_pkg::byte_t       gmii_rxdata,
	output udp_rx_pkg::frame_sect_t sect,
	output udp_rx_pkg::sect_cnt_t   sect_cnt,
	output udp_rx_pkg::byte_t       rx_byte,
	output logic                    rx_valid,
	output udp_rx_pkg::len_t        payload_len
);

	udp_rx_pkg::frame_sect_t state;     // section of the incoming byte
	udp_rx_pkg::sect_cnt_t   cnt;       // wraps in payload and drain
	udp_rx_pkg::sect_cnt_t   ip_last;   // position of the last ip header byte
	udp_rx_pkg::len_t        udp_len;
	udp_rx_pkg::len_t        pay_left;  // payload bytes after the current one

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= udp_rx_pkg::SECT_IDLE;
			cnt <= '0;
		end else if (!gmii_rxdv) begin
			state <= udp_rx_pkg::SECT_IDLE; // frame ends on any gap
			cnt <= '0;
		end else begin
			case (state)
				udp_rx_pkg::SECT_IDLE: begin
					if (gmii_rxdata != `ETH_PREAMBLE_BYTE) begin
						cnt <= '0;
					end else if (cnt == udp_rx_pkg::sect_cnt_t'(`ETH_PREAMBLE_MIN - 1)) begin
						state <= udp_rx_pkg::SECT_SFD;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				udp_rx_pkg::SECT_SFD: begin
					if (gmii_rxdata == `ETH_SFD_BYTE) begin
						state <= udp_rx_pkg::SECT_ETH;
					end else if (gmii_rxdata != `ETH_PREAMBLE_BYTE) begin
						state <= udp_rx_pkg::SECT_IDLE;
					end
				end
				udp_rx_pkg::SECT_ETH: begin
					if (cnt == udp_rx_pkg::sect_cnt_t'(`ETH_HDR_BYTES - 1)) begin
						state <= udp_rx_pkg::SECT_IP;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				udp_rx_pkg::SECT_IP: begin
					// ip_last is only valid once the first byte is in
					if (cnt != '0 && cnt == ip_last) begin
						state <= udp_rx_pkg::SECT_UDP;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				udp_rx_pkg::SECT_UDP: begin
					if (cnt == udp_rx_pkg::sect_cnt_t'(`UDP_HDR_BYTES - 1)) begin
						cnt <= '0;
						if (udp_len > udp_rx_pkg::len_t'(`UDP_HDR_BYTES)) begin
							state <= udp_rx_pkg::SECT_PAYLOAD;
						end else begin
							state <= udp_rx_pkg::SECT_DRAIN; // empty datagram
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				udp_rx_pkg::SECT_PAYLOAD: begin
					cnt <= cnt + 1'b1;
					if (pay_left == '0) begin
						state <= udp_rx_pkg::SECT_DRAIN;
						cnt <= '0;
					end
				end
				udp_rx_pkg::SECT_DRAIN: begin
					cnt <= cnt + 1'b1;
				end
				default: begin
					state <= udp_rx_pkg::SECT_IDLE;
					cnt <= '0;
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			ip_last <= '0;
			udp_len <= '0;
			payload_len <= '0;
			pay_left <= '0;
		end else if (gmii_rxdv) begin
			if (state == udp_rx_pkg::SECT_IP && cnt == '0) begin
				ip_last <= {gmii_rxdata[3:0], 2'b00} - 6'd1; // ihl in 32-bit words
			end
			if (state == udp_rx_pkg::SECT_UDP && cnt == 6'd4) begin
				udp_len[15:8] <= gmii_rxdata;
			end
			if (state == udp_rx_pkg::SECT_UDP && cnt == 6'd5) begin
				udp_len[7:0] <= gmii_rxdata;
			end
			if (state == udp_rx_pkg::SECT_UDP && cnt == 6'd7) begin
				payload_len <= udp_len - udp_rx_pkg::len_t'(`UDP_HDR_BYTES);
				pay_left <= udp_len - udp_rx_pkg::len_t'(`UDP_HDR_BYTES + 1);
			end
			if (state == udp_rx_pkg::SECT_PAYLOAD) begin
				pay_left <= pay_left - 16'd1;
			end
		end
	end

	// byte stage seen by the side blocks, one cycle behind gmii
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_valid <= 1'b0;
			sect <= udp_rx_pkg::SECT_IDLE;
			sect_cnt <= '0;
		end else begin
			rx_valid <= gmii_rxdv && state != udp_rx_pkg::SECT_IDLE &&
				state != udp_rx_pkg::SECT_SFD;
			sect <= gmii_rxdv ? state : udp_rx_pkg::SECT_IDLE;
			sect_cnt <= cnt;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (gmii_rxdv) begin
			rx_byte <= gmii_rxdata;
		end
	end

endmodule

// ==== src/udp_header_match.sv ====
// UDP header match
// checks destination MAC, ethertype, ip version and header length,
// protocol and destination ip against the board values as the bytes pass.
// hdr_ok rises when the udp header starts and holds until the next frame.

`include "udp_rx_defines.svh"

module udp_header_match (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  udp_rx_pkg::frame_sect_t sect,
	input  udp_rx_pkg::sect_cnt_t   sect_cnt,
	input  udp_rx_pkg::byte_t       rx_byte,
	input  logic                    rx_valid,
	output logic                    hdr_ok
);

	localparam udp_rx_pkg::mac_addr_t BOARD_MAC = `UDP_BOARD_MAC;
	localparam udp_rx_pkg::ip_addr_t  BOARD_IP  = `UDP_BOARD_IP;
	localparam logic [15:0]           ETH_TYPE  = `ETH_TYPE_IPV4;

	logic match;                        // all checks so far passed
	logic hit;                          // current byte passes its check

	always_comb begin
		hit = 1'b1;
		case (sect)
			udp_rx_pkg::SECT_ETH: begin
				if (sect_cnt < 6'd6) begin
					hit = rx_byte == BOARD_MAC[(5 - sect_cnt) * 8 +: 8];
				end else if (sect_cnt >= 6'd12) begin
					hit = rx_byte == ETH_TYPE[(13 - sect_cnt) * 8 +: 8];
				end
			end
			udp_rx_pkg::SECT_IP: begin
				if (sect_cnt == 6'd0) begin
					// short headers would hide the fields below
					hit = rx_byte[7:4] == `IP_VERSION_4 && rx_byte[3:0] >= 4'd5;
				end else if (sect_cnt == 6'd9) begin
					hit = rx_byte == `IP_PROTO_UDP;
				end else if (sect_cnt >= 6'd16 && sect_cnt <= 6'd19) begin
					hit = rx_byte == BOARD_IP[(19 - sect_cnt) * 8 +: 8];
				end
			end
			default: begin
				hit = 1'b1;
			end
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			match <= 1'b0;
			hdr_ok <= 1'b0;
		end else if (rx_valid) begin
			if (sect == udp_rx_pkg::SECT_ETH && sect_cnt == '0) begin
				match <= hit;           // new frame
				hdr_ok <= 1'b0;
			end else if (sect == udp_rx_pkg::SECT_UDP && sect_cnt == '0) begin
				hdr_ok <= match;        // ip header complete
			end else begin
				match <= match & hit;
			end
		end
	end

endmodule

// ==== src/udp_peer_capture.sv ====
// UDP peer capture
// shifts source MAC, source ip and both udp ports into holding registers
// by section position for every frame; acceptance is decided elsewhere

module udp_peer_capture (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  udp_rx_pkg::frame_sect_t sect,
	input  udp_rx_pkg::sect_cnt_t   sect_cnt,
	input  udp_rx_pkg::byte_t       rx_byte,
	input  logic                    rx_valid,
	output udp_rx_pkg::mac_addr_t   cap_mac,
	output udp_rx_pkg::ip_addr_t    cap_ip,
	output udp_rx_pkg::udp_port_t   cap_src_port,
	output udp_rx_pkg::udp_port_t   cap_dst_port
);

	logic in_src_mac;
	logic in_src_ip;
	logic in_src_port;
	logic in_dst_port;

	// byte positions, network order, msb first
	assign in_src_mac  = sect == udp_rx_pkg::SECT_ETH && sect_cnt >= 6'd6 &&
		sect_cnt <= 6'd11;
	assign in_src_ip   = sect == udp_rx_pkg::SECT_IP && sect_cnt >= 6'd12 &&
		sect_cnt <= 6'd15;
	assign in_src_port = sect == udp_rx_pkg::SECT_UDP && sect_cnt <= 6'd1;
	assign in_dst_port = sect == udp_rx_pkg::SECT_UDP &&
		(sect_cnt == 6'd2 || sect_cnt == 6'd3);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cap_mac <= '0;
			cap_ip <= '0;
			cap_src_port <= '0;
			cap_dst_port <= '0;
		end else if (rx_valid) begin
			if (in_src_mac) begin
				cap_mac <= {cap_mac[39:0], rx_byte};
			end
			if (in_src_ip) begin
				cap_ip <= {cap_ip[23:0], rx_byte};
			end
			if (in_src_port) begin
				cap_src_port <= {cap_src_port[7:0], rx_byte};
			end
			if (in_dst_port) begin
				cap_dst_port <= {cap_dst_port[7:0], rx_byte};
			end
		end
	end

endmodule

// ==== src/udp_payload_emit.sv ====
// UDP payload output
// passes payload bytes of accepted frames with start and end pulses and a
// 1-based index. The amount and the peer fields are latched on the first
// accepted byte, so a rejected frame leaves every output unchanged.

module udp_payload_emit (
	input  logic                    sys_clk,
	input  logic                    sys_rst_n,
	input  udp_rx_pkg::frame_sect_t sect,
	input  udp_rx_pkg::byte_t       rx_byte,
	input  logic                    rx_valid,
	input  udp_rx_pkg::len_t        payload_len,
	input  logic                    hdr_ok,
	input  udp_rx_pkg::mac_addr_t   cap_mac,
	input  udp_rx_pkg::ip_addr_t    cap_ip,
	input  udp_rx_pkg::udp_port_t   cap_src_port,
	input  udp_rx_pkg::udp_port_t   cap_dst_port,
	output logic                    udp_rxstart,
	output logic                    udp_rxend,
	output logic                    udp_rxdv,
	output udp_rx_pkg::byte_t       udp_rxdata,
	output udp_rx_pkg::len_t        udp_rxamount,
	output udp_rx_pkg::len_t        udp_rxnum,
	output udp_rx_pkg::mac_addr_t   pc_mac_addr,
	output udp_rx_pkg::ip_addr_t    pc_ip_addr,
	output udp_rx_pkg::udp_port_t   pc_port,
	output udp_rx_pkg::udp_port_t   board_port
);

	udp_rx_pkg::len_t pay_idx;          // payload bytes passed in this frame
	logic             take;
	logic             first_byte;
	logic             last_byte;

	assign take       = rx_valid && hdr_ok && sect == udp_rx_pkg::SECT_PAYLOAD;
	assign first_byte = pay_idx == '0;
	assign last_byte  = pay_idx == payload_len - 16'd1;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			pay_idx <= '0;
		end else if (sect != udp_rx_pkg::SECT_PAYLOAD) begin
			pay_idx <= '0;              // also clears after a cut frame
		end else if (take) begin
			pay_idx <= pay_idx + 16'd1;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			udp_rxdv <= 1'b0;
			udp_rxstart <= 1'b0;
			udp_rxend <= 1'b0;
			udp_rxdata <= '0;
			udp_rxnum <= '0;
		end else begin
			udp_rxdv <= take;
			udp_rxstart <= take && first_byte;
			udp_rxend <= take && last_byte;
			if (take) begin
				udp_rxdata <= rx_byte;
				udp_rxnum <= pay_idx + 16'd1;
			end
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			udp_rxamount <= '0;
			pc_mac_addr <= '0;
			pc_ip_addr <= '0;
			pc_port <= '0;
			board_port <= '0;
		end else if (take && first_byte) begin
			udp_rxamount <= payload_len;
			pc_mac_addr <= cap_mac;
			pc_ip_addr <= cap_ip;
			pc_port <= cap_src_port;
			board_port <= cap_dst_port;
		end
	end

endmodule

// ==== src/udp_gmii_rx.sv ====
// UDP over IPv4 receiver, GMII side
// the sequencer tags the byte stream, header match and peer capture work
// on it side by side, and the payload block merges their results

module udp_gmii_rx (
	input  logic                  sys_clk,
	input  logic                  sys_rst_n,
	input  logic                  gmii_rxdv,
	input  udp_rx_pkg::byte_t     gmii_rxdata,
	output logic                  udp_rxstart,
	output logic                  udp_rxend,
	output logic                  udp_rxdv,
	output udp_rx_pkg::byte_t     udp_rxdata,
	output udp_rx_pkg::len_t      udp_rxamount,
	output udp_rx_pkg::len_t      udp_rxnum,
	output udp_rx_pkg::mac_addr_t pc_mac_addr,
	output udp_rx_pkg::ip_addr_t  pc_ip_addr,
	output udp_rx_pkg::udp_port_t pc_port,
	output udp_rx_pkg::udp_port_t board_port
);

	udp_rx_pkg::frame_sect_t sect;
	udp_rx_pkg::sect_cnt_t   sect_cnt;
	udp_rx_pkg::byte_t       rx_byte;
	logic                    rx_valid;
	udp_rx_pkg::len_t        payload_len;
	logic                    hdr_ok;
	udp_rx_pkg::mac_addr_t   cap_mac;
	udp_rx_pkg::ip_addr_t    cap_ip;
	udp_rx_pkg::udp_port_t   cap_src_port;
	udp_rx_pkg::udp_port_t   cap_dst_port;

	eth_rx_sequencer u_sequencer (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.gmii_rxdv   (gmii_rxdv),
		.gmii_rxdata (gmii_rxdata),
		.sect        (sect),
		.sect_cnt    (sect_cnt),
		.rx_byte     (rx_byte),
		.rx_valid    (rx_valid),
		.payload_len (payload_len)
	);

	udp_header_match u_header_match (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.sect      (sect),
		.sect_cnt  (sect_cnt),
		.rx_byte   (rx_byte),
		.rx_valid  (rx_valid),
		.hdr_ok    (hdr_ok)
	);

	udp_peer_capture u_peer_capture (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.sect         (sect),
		.sect_cnt     (sect_cnt),
		.rx_byte      (rx_byte),
		.rx_valid     (rx_valid),
		.cap_mac      (cap_mac),
		.cap_ip       (cap_ip),
		.cap_src_port (cap_src_port),
		.cap_dst_port (cap_dst_port)
	);

	udp_payload_emit u_payload_emit (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.sect         (sect),
		.rx_byte      (rx_byte),
		.rx_valid     (rx_valid),
		.payload_len  (payload_len),
		.hdr_ok       (hdr_ok),
		.cap_mac      (cap_mac),
		.cap_ip       (cap_ip),
		.cap_src_port (cap_src_port),
		.cap_dst_port (cap_dst_port),
		.udp_rxstart  (udp_rxstart),
		.udp_rxend    (udp_rxend),
		.udp_rxdv     (udp_rxdv),
		.udp_rxdata   (udp_rxdata),
		.udp_rxamount (udp_rxamount),
		.udp_rxnum    (udp_rxnum),
		.pc_mac_addr  (pc_mac_addr),
		.pc_ip_addr   (pc_ip_addr),
		.pc_port      (pc_port),
		.board_port   (board_port)
	);

endmodule

// ==== dv/tb_udp_gmii_rx.sv ====
// UDP receiver testbench
// replays Ethernet frames from the test data file on the GMII input,
// collects the payload strobes and checks bytes, index, amount and the
// peer fields against values derived from each frame

module tb_udp_gmii_rx;

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 2;
	localparam int IDLE_MIN     = 2;
	localparam int IDLE_MAX     = 20;
	localparam int LEAD_BYTES   = 8;        // preamble and delimiter
	localparam int END_TIMEOUT  = 16;       // cycles to wait for udp_rxend
	localparam int MAX_TESTS    = 16;
	localparam int MAX_BYTES    = 256;

	logic                  sys_clk;
	logic                  sys_rst_n;
	logic                  gmii_rxdv;
	udp_rx_pkg::byte_t     gmii_rxdata;
	logic                  udp_rxstart;
	logic                  udp_rxend;
	logic                  udp_rxdv;
	udp_rx_pkg::byte_t     udp_rxdata;
	udp_rx_pkg::len_t      udp_rxamount;
	udp_rx_pkg::len_t      udp_rxnum;
	udp_rx_pkg::mac_addr_t pc_mac_addr;
	udp_rx_pkg::ip_addr_t  pc_ip_addr;
	udp_rx_pkg::udp_port_t pc_port;
	udp_rx_pkg::udp_port_t board_port;

	// test records
	string                 test_name [MAX_TESTS];
	bit                    test_accept [MAX_TESTS];
	udp_rx_pkg::mac_addr_t test_mac [MAX_TESTS];
	udp_rx_pkg::ip_addr_t  test_ip [MAX_TESTS];
	udp_rx_pkg::udp_port_t test_sport [MAX_TESTS];
	udp_rx_pkg::udp_port_t test_dport [MAX_TESTS];
	int                    test_len [MAX_TESTS];
	int                    test_nbytes [MAX_TESTS];
	udp_rx_pkg::byte_t     frame_mem [MAX_TESTS][MAX_BYTES];
	int                    num_tests;
	bit                    load_done;

	// values the outputs hold since the last accepted frame
	udp_rx_pkg::mac_addr_t hold_mac;
	udp_rx_pkg::ip_addr_t  hold_ip;
	udp_rx_pkg::udp_port_t hold_sport;
	udp_rx_pkg::udp_port_t hold_dport;
	udp_rx_pkg::len_t      hold_amount;
	udp_rx_pkg::len_t      hold_num;

	udp_rx_pkg::byte_t     obs_data [$];
	udp_rx_pkg::len_t      obs_num [$];
	int                    start_cnt;
	int                    end_cnt;
	udp_rx_pkg::len_t      start_num;
	udp_rx_pkg::len_t      end_num;

	int                    error_count;
	int                    check_count;

	udp_gmii_rx u_udp_gmii_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.gmii_rxdv    (gmii_rxdv),
		.gmii_rxdata  (gmii_rxdata),
		.udp_rxstart  (udp_rxstart),
		.udp_rxend    (udp_rxend),
		.udp_rxdv     (udp_rxdv),
		.udp_rxdata   (udp_rxdata),
		.udp_rxamount (udp_rxamount),
		.udp_rxnum    (udp_rxnum),
		.pc_mac_addr  (pc_mac_addr),
		.pc_ip_addr   (pc_ip_addr),
		.pc_port      (pc_port),
		.board_port   (board_port)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// outputs are stable at the falling edge
	always @(negedge sys_clk) begin
		if (udp_rxdv) begin
			obs_data.push_back(udp_rxdata);
			obs_num.push_back(udp_rxnum);
		end
		if (udp_rxstart) begin
			start_cnt++;
			start_num = udp_rxnum;
		end
		if (udp_rxend) begin
			end_cnt++;
			end_num = udp_rxnum;
		end
	end

	task automatic check_byte(input string name, input udp_rx_pkg::byte_t exp,
		input udp_rx_pkg::byte_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_len(input string name, input udp_rx_pkg::len_t exp,
		input udp_rx_pkg::len_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("[FAIL] t=%0t %s expected %0d actual %0d", $time, name, exp, act);
		end
	endtask

	task automatic check_mac(input string name, input udp_rx_pkg::mac_addr_t exp,
		input udp_rx_pkg::mac_addr_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_ip(input string name, input udp_rx_pkg::ip_addr_t exp,
		input udp_rx_pkg::ip_addr_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_port(input string name, input udp_rx_pkg::udp_port_t exp,
		input udp_rx_pkg::udp_port_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic check_strobe(input string name, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
		end
	endtask

	task automatic send_byte(input udp_rx_pkg::byte_t b);
		@(negedge sys_clk);
		gmii_rxdv = 1'b1;
		gmii_rxdata = b;
	endtask

	task automatic drive_frame(input int t);
		int i;
		for (i = 0; i < LEAD_BYTES - 1; i++) begin
			send_byte(8'h55);
		end
		send_byte(8'hd5);
		for (i = 0; i < test_nbytes[t]; i++) begin
			send_byte(frame_mem[t][i]);
		end
		@(negedge sys_clk);
		gmii_rxdv = 1'b0;
		gmii_rxdata = '0;
	endtask

	task automatic load_tests();
		int fd;
		int code;
		int ch;
		int i;
		int acc;
		int plen;
		int nb;
		bit done;
		string tok;
		udp_rx_pkg::mac_addr_t mac;
		udp_rx_pkg::ip_addr_t ip;
		udp_rx_pkg::udp_port_t sp;
		udp_rx_pkg::udp_port_t dp;
		udp_rx_pkg::byte_t b;
		num_tests = 0;
		done = 1'b0;
		fd = $fopen("dv/udp_rx_testdata.txt", "r");
		if (fd == 0) begin
			$display("cannot open the test data file dv/udp_rx_testdata.txt");
			done = 1'b1;
		end
		while (!done) begin
			code = $fscanf(fd, "%s", tok);
			if (code != 1) begin
				done = 1'b1;
			end else if (tok.getc(0) == "#") begin
				ch = $fgetc(fd);            // comment runs to end of line
				while (ch != 10 && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else begin
				code = $fscanf(fd, "%d %h %h %h %h %d %d", acc, mac, ip, sp, dp, plen, nb);
				if (code != 7 || nb > MAX_BYTES || num_tests == MAX_TESTS) begin
					$display("bad test record %s in the test data file", tok);
					error_count++;
					done = 1'b1;
				end else begin
					test_name[num_tests] = tok;
					test_accept[num_tests] = acc != 0;
					test_mac[num_tests] = mac;
					test_ip[num_tests] = ip;
					test_sport[num_tests] = sp;
					test_dport[num_tests] = dp;
					test_len[num_tests] = plen;
					test_nbytes[num_tests] = nb;
					for (i = 0; i < nb; i++) begin
						code = $fscanf(fd, "%h", b);
						frame_mem[num_tests][i] = b;
					end
					num_tests++;
				end
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
	endtask

	task automatic check_reset_values();
		int errs_before;
		errs_before = error_count;
		@(negedge sys_clk);
		check_strobe("udp_rxstart", 1'b0, udp_rxstart);
		check_strobe("udp_rxend", 1'b0, udp_rxend);
		check_strobe("udp_rxdv", 1'b0, udp_rxdv);
		check_byte("udp_rxdata", '0, udp_rxdata);
		check_len("udp_rxamount", '0, udp_rxamount);
		check_len("udp_rxnum", '0, udp_rxnum);
		check_mac("pc_mac_addr", '0, pc_mac_addr);
		check_ip("pc_ip_addr", '0, pc_ip_addr);
		check_port("pc_port", '0, pc_port);
		check_port("board_port", '0, board_port);
		$display("test %-14s %0d errors", "reset_values", error_count - errs_before);
	endtask

	task automatic run_test(input int t);
		int errs_before;
		int ihl;
		int base;
		int n;
		int i;
		int waited;
		int idle;
		errs_before = error_count;
		@(posedge sys_clk);
		obs_data.delete();
		obs_num.delete();
		start_cnt = 0;
		end_cnt = 0;
		drive_frame(t);
		if (test_accept[t]) begin
			waited = 0;
			while (end_cnt == 0 && waited < END_TIMEOUT) begin
				@(posedge sys_clk);
				waited++;
			end
			if (end_cnt == 0) begin
				$display("no udp_rxend within %0d cycles after frame %s", END_TIMEOUT,
					test_name[t]);
				error_count++;
			end
		end
		idle = IDLE_MIN + int'($urandom % (IDLE_MAX - IDLE_MIN + 1));
		repeat (idle) @(negedge sys_clk);
		@(posedge sys_clk);
		if (test_accept[t]) begin
			ihl = frame_mem[t][14][3:0];
			base = 14 + 4 * ihl + 8;        // first payload byte
			n = test_len[t];
			check_len("udp_rxdv byte count", n, obs_data.size());
			for (i = 0; i < n && i < obs_data.size(); i++) begin
				check_byte("udp_rxdata", frame_mem[t][base + i], obs_data[i]);
				check_len("udp_rxnum", i + 1, obs_num[i]);
			end
			check_len("udp_rxstart pulses", 1, start_cnt);
			check_len("udp_rxnum at udp_rxstart", 1, start_num);
			check_len("udp_rxend pulses", 1, end_cnt);
			check_len("udp_rxnum at udp_rxend", n, end_num);
			hold_mac = test_mac[t];
			hold_ip = test_ip[t];
			hold_sport = test_sport[t];
			hold_dport = test_dport[t];
			hold_amount = n;
			hold_num = n;
		end else begin
			check_len("udp_rxdv byte count", 0, obs_data.size());
			check_len("udp_rxstart pulses", 0, start_cnt);
			check_len("udp_rxend pulses", 0, end_cnt);
		end
		check_len("udp_rxamount", hold_amount, udp_rxamount);
		check_len("udp_rxnum", hold_num, udp_rxnum);
		check_mac("pc_mac_addr", hold_mac, pc_mac_addr);
		check_ip("pc_ip_addr", hold_ip, pc_ip_addr);
		check_port("pc_port", hold_sport, pc_port);
		check_port("board_port", hold_dport, board_port);
		$display("test %-14s %0d errors", test_name[t], error_count - errs_before);
	endtask

	initial begin
		sys_rst_n = 1'b0;
		gmii_rxdv = 1'b0;
		gmii_rxdata = '0;
		error_count = 0;
		check_count = 0;
		start_cnt = 0;
		end_cnt = 0;
		start_num = '0;
		end_num = '0;
		hold_mac = '0;
		hold_ip = '0;
		hold_sport = '0;
		hold_dport = '0;
		hold_amount = '0;
		hold_num = '0;
		load_done = 1'b0;
		void'($urandom(65599));
		load_tests();
		load_done = 1'b1;
		repeat (RESET_CYCLES) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst_n = 1'b1;
		check_reset_values();
		if (num_tests == 0) begin
			$display("no frames were read from the test data file");
			error_count++;
		end
		for (int t = 0; t < num_tests; t++) begin
			run_test(t);
		end
		$display("%0d frames, %0d checks, %0d errors", num_tests, check_count, error_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		int limit_cycles;
		wait (load_done);
		limit_cycles = RESET_CYCLES + 4;
		for (int t = 0; t < num_tests; t++) begin
			limit_cycles += test_nbytes[t] + LEAD_BYTES + END_TIMEOUT + IDLE_MAX + 4;
		end
		#(limit_cycles * CLK_PERIOD * 2);
		$display("watchdog: run did not finish within %0d cycles", limit_cycles * 2);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+src
src/udp_rx_pkg.sv
src/eth_rx_sequencer.sv
src/udp_header_match.sv
src/udp_peer_capture.sv
src/udp_payload_emit.sv
src/udp_gmii_rx.sv
dv/tb_udp_gmii_rx.sv

// ==== dv/udp_rx_testdata.txt ====
# name accept src_mac src_ip src_port dst_port payload_len byte_count
# followed by byte_count frame bytes in hex, destination MAC through FCS, no preamble
basic_accept 1 02aabbccdd01 c0a81f0a 1f90 04d2 8 54
00 11 22 33 44 55 02 aa bb cc dd 01 08 00 45 00 00 24 00 01
00 00 40 11 00 00 c0 a8 1f 0a c0 a8 1f 17 1f 90 04 d2 00 10
00 00 a0 a1 a2 a3 a4 a5 a6 a7 de ad be ef

bad_dst_mac 0 02aabbccdd02 c0a81f0b 1388 04d2 8 54
00 11 22 33 44 56 02 aa bb cc dd 02 08 00 45 00 00 24 00 01
00 00 40 11 00 00 c0 a8 1f 0b c0 a8 1f 17 13 88 04 d2 00 10
00 00 b0 b1 b2 b3 b4 b5 b6 b7 de ad be ef

bad_ethertype 0 02aabbccdd02 c0a81f0b 1388 04d2 8 54
00 11 22 33 44 55 02 aa bb cc dd 02 08 06 45 00 00 24 00 01
00 00 40 11 00 00 c0 a8 1f 0b c0 a8 1f 17 13 88 04 d2 00 10
00 00 b0 b1 b2 b3 b4 b5 b6 b7 de ad be ef

bad_protocol 0 02aabbccdd02 c0a81f0b 1388 04d2 8 54
00 11 22 33 44 55 02 aa bb cc dd 02 08 00 45 00 00 24 00 01
00 00 40 06 00 00 c0 a8 1f 0b c0 a8 1f 17 13 88 04 d2 00 10
00 00 b0 b1 b2 b3 b4 b5 b6 b7 de ad be ef

bad_dst_ip 0 02aabbccdd02 c0a81f0b 1388 04d2 8 54
00 11 22 33 44 55 02 aa bb cc dd 02 08 00 45 00 00 24 00 01
00 00 40 11 00 00 c0 a8 1f 0b c0 a8 1f 18 13 88 04 d2 00 10
00 00 b0 b1 b2 b3 b4 b5 b6 b7 de ad be ef

ip_options 1 02aabbccdd03 c0a81f0c 2710 1770 10 60
00 11 22 33 44 55 02 aa bb cc dd 03 08 00 46 00 00 2a 00 02
00 00 40 11 00 00 c0 a8 1f 0c c0 a8 1f 17 01 02 03 04 27 10
17 70 00 12 00 00 c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 12 34 56 78

short_padded 1 02aabbccdd04 c0a81f0d 0fa0 0bb8 3 64
00 11 22 33 44 55 02 aa bb cc dd 04 08 00 45 00 00 1f 00 03
00 00 40 11 00 00 c0 a8 1f 0d c0 a8 1f 17 0f a0 0b b8 00 0b
00 00 d0 d1 d2 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
9a bc de f0
